//--- board_test_pkg.sv
// register map, sizes and shared structs for the board memory test
package board_test_pkg;

    typedef logic [7:0] reg_addr_t;
    typedef logic [7:0] reg_data_t;

    localparam int SRAM_ADDR_W    = 19;
    localparam int SRAM_DATA_W    = 16;
    localparam int SRAM_PAGE_BITS = 4;  // low address bits per top-address step
    localparam int HEARTBEAT_BITS = 25;
    localparam int RUNS_W         = 32;

    // register map
    localparam reg_addr_t ADDR_SRAM_CTRL   = 8'h00; // bit0 tester enable
    localparam reg_addr_t ADDR_TOP_ADDR    = 8'h01;
    localparam reg_addr_t ADDR_WRITE_WAIT1 = 8'h02;
    localparam reg_addr_t ADDR_WRITE_WAIT2 = 8'h03;
    localparam reg_addr_t ADDR_READ_WAIT   = 8'h04;
    localparam reg_addr_t ADDR_SRAM_STATUS = 8'h05; // read only: pass, fail, busy
    localparam reg_addr_t ADDR_RUNS0       = 8'h08; // run count, lsb first
    localparam reg_addr_t ADDR_RUNS1       = 8'h09;
    localparam reg_addr_t ADDR_RUNS2       = 8'h0A;
    localparam reg_addr_t ADDR_RUNS3       = 8'h0B;
    localparam reg_addr_t ADDR_LED_CTRL    = 8'h10; // bit0 test mode, bit1 flash all
    localparam reg_addr_t ADDR_TEST_LEDS   = 8'h11;
    localparam reg_addr_t ADDR_DIPS        = 8'h12; // read only
    localparam reg_addr_t ADDR_USER_LED    = 8'h13;

    // tester configuration from the register block
    typedef struct packed {
        logic       enable;
        logic [7:0] top_addr;
        logic [7:0] write_wait1;
        logic [7:0] write_wait2;
        logic [7:0] read_wait;
    } sram_cfg_t;

    typedef struct packed {
        logic              pass;
        logic              fail;  // sticky until next enable
        logic              busy;
        logic [RUNS_W-1:0] runs;
    } sram_status_t;

    // SRAM pins, data bus split so no tristate in the core
    typedef struct packed {
        logic [SRAM_ADDR_W-1:0] addr;
        logic [SRAM_DATA_W-1:0] dq_out;
        logic                   dq_oe;
        logic                   ce_n;
        logic                   we_n;
        logic                   oe_n;
        logic                   lb_n;
        logic                   ub_n;
    } sram_pins_t;

    typedef struct packed {
        logic       test_mode;
        logic       flash_all;
        logic [7:0] test_leds;
        logic       user_led;
    } led_cfg_t;

endpackage

//--- test_reg_block.sv
// byte register file: tester and LED configuration, status readback
module test_reg_block (
    input  logic                          ext_clk,
    input  logic                          rst_i,
    input  board_test_pkg::reg_addr_t     reg_addr_i,
    input  board_test_pkg::reg_data_t     reg_wdata_i,
    input  logic                          reg_write_i,
    input  logic                          reg_read_i,
    output board_test_pkg::reg_data_t     reg_rdata_o,
    input  logic [7:0]                    dips_i,
    input  board_test_pkg::sram_status_t  sram_status_i,
    output board_test_pkg::sram_cfg_t     sram_cfg_o,
    output board_test_pkg::led_cfg_t      led_cfg_o
);

    board_test_pkg::sram_cfg_t sram_cfg_q;
    board_test_pkg::led_cfg_t  led_cfg_q;
    board_test_pkg::reg_data_t rd_sel;   // value at the current address
    board_test_pkg::reg_data_t rdata_q;

    // write decode
    always_ff @(posedge ext_clk) begin
        if (rst_i) begin
            sram_cfg_q <= '0;
            led_cfg_q  <= '0;
        end else if (reg_write_i) begin
            case (reg_addr_i)
                board_test_pkg::ADDR_SRAM_CTRL:   sram_cfg_q.enable      <= reg_wdata_i[0];
                board_test_pkg::ADDR_TOP_ADDR:    sram_cfg_q.top_addr    <= reg_wdata_i;
                board_test_pkg::ADDR_WRITE_WAIT1: sram_cfg_q.write_wait1 <= reg_wdata_i;
                board_test_pkg::ADDR_WRITE_WAIT2: sram_cfg_q.write_wait2 <= reg_wdata_i;
                board_test_pkg::ADDR_READ_WAIT:   sram_cfg_q.read_wait   <= reg_wdata_i;
                board_test_pkg::ADDR_LED_CTRL: begin
                    led_cfg_q.test_mode <= reg_wdata_i[0];
                    led_cfg_q.flash_all <= reg_wdata_i[1];
                end
                board_test_pkg::ADDR_TEST_LEDS:   led_cfg_q.test_leds    <= reg_wdata_i;
                board_test_pkg::ADDR_USER_LED:    led_cfg_q.user_led     <= reg_wdata_i[0];
                default: ;                        // read-only or unmapped
            endcase
        end
    end

    // read mux
    always_comb begin
        rd_sel = '0;
        case (reg_addr_i)
            board_test_pkg::ADDR_SRAM_CTRL:   rd_sel = {7'b0, sram_cfg_q.enable};
            board_test_pkg::ADDR_TOP_ADDR:    rd_sel = sram_cfg_q.top_addr;
            board_test_pkg::ADDR_WRITE_WAIT1: rd_sel = sram_cfg_q.write_wait1;
            board_test_pkg::ADDR_WRITE_WAIT2: rd_sel = sram_cfg_q.write_wait2;
            board_test_pkg::ADDR_READ_WAIT:   rd_sel = sram_cfg_q.read_wait;
            board_test_pkg::ADDR_SRAM_STATUS: begin
                rd_sel = {5'b0, sram_status_i.busy, sram_status_i.fail, sram_status_i.pass};
            end
            board_test_pkg::ADDR_RUNS0:       rd_sel = sram_status_i.runs[7:0];
            board_test_pkg::ADDR_RUNS1:       rd_sel = sram_status_i.runs[15:8];
            board_test_pkg::ADDR_RUNS2:       rd_sel = sram_status_i.runs[23:16];
            board_test_pkg::ADDR_RUNS3:       rd_sel = sram_status_i.runs[31:24];
            board_test_pkg::ADDR_LED_CTRL: begin
                rd_sel = {6'b0, led_cfg_q.flash_all, led_cfg_q.test_mode};
            end
            board_test_pkg::ADDR_TEST_LEDS:   rd_sel = led_cfg_q.test_leds;
            board_test_pkg::ADDR_DIPS:        rd_sel = dips_i;
            board_test_pkg::ADDR_USER_LED:    rd_sel = {7'b0, led_cfg_q.user_led};
            default:                          rd_sel = '0;
        endcase
    end

    // read data held until the next read strobe
    always_ff @(posedge ext_clk) begin
        if (rst_i) begin
            rdata_q <= '0;
        end else if (reg_read_i) begin
            rdata_q <= rd_sel;
        end
    end

    assign reg_rdata_o = rdata_q;
    assign sram_cfg_o  = sram_cfg_q;
    assign led_cfg_o   = led_cfg_q;

endmodule

//--- sram_rwtest.sv
// SRAM write/read-back tester FSM with pattern check and run counter
module sram_rwtest (
    input  logic                                    ext_clk,
    input  logic                                    rst_i,
    input  board_test_pkg::sram_cfg_t               cfg_i,
    output board_test_pkg::sram_status_t            status_o,
    output board_test_pkg::sram_pins_t              sram_o,
    input  logic [board_test_pkg::SRAM_DATA_W-1:0]  sram_dq_i
);

    typedef logic [board_test_pkg::SRAM_ADDR_W-1:0] sram_addr_t;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_WR_SETUP,   // addr/data valid, we_n high
        ST_WR_STROBE,  // we_n low
        ST_READ,       // oe_n low, sample on last cycle
        ST_NEXT        // word boundary
    } state_t;

    state_t                                  state;
    logic [7:0]                              wait_cnt;
    sram_addr_t                              addr;
    sram_addr_t                              last_addr;
    logic                                    read_phase;
    logic                                    en_q;
    logic                                    start_req;  // rise seen, not yet taken
    logic                                    start_now;
    logic                                    access;
    logic                                    pass;
    logic                                    fail;
    logic [board_test_pkg::RUNS_W-1:0]       runs;
    logic [board_test_pkg::SRAM_DATA_W-1:0]  pattern;

    assign last_addr = sram_addr_t'({cfg_i.top_addr, {board_test_pkg::SRAM_PAGE_BITS{1'b1}}});
    // odd runs use the inverted pattern
    assign pattern   = addr[board_test_pkg::SRAM_DATA_W-1:0]
                       ^ {board_test_pkg::SRAM_DATA_W{runs[0]}};
    assign start_now = start_req | (cfg_i.enable & ~en_q);

    always_ff @(posedge ext_clk) begin
        if (rst_i) begin
            state      <= ST_IDLE;
            wait_cnt   <= '0;
            addr       <= '0;
            read_phase <= 1'b0;
            en_q       <= 1'b0;
            start_req  <= 1'b0;
            pass       <= 1'b0;
            fail       <= 1'b0;
            runs       <= '0;
        end else begin
            en_q <= cfg_i.enable;
            if (cfg_i.enable & ~en_q) begin
                start_req <= 1'b1;
            end
            if ((state == ST_IDLE || state == ST_NEXT) && start_now) begin
                start_req  <= 1'b0;     // restart clears results
                pass       <= 1'b0;
                fail       <= 1'b0;
                runs       <= '0;
                addr       <= '0;
                read_phase <= 1'b0;
                wait_cnt   <= '0;
                state      <= ST_WR_SETUP;
            end else begin
                case (state)
                    ST_WR_SETUP: begin
                        if (wait_cnt == cfg_i.write_wait1) begin
                            wait_cnt <= '0;
                            state    <= ST_WR_STROBE;
                        end else begin
                            wait_cnt <= wait_cnt + 8'd1;
                        end
                    end
                    ST_WR_STROBE: begin
                        if (wait_cnt == cfg_i.write_wait2) begin
                            wait_cnt <= '0;
                            state    <= ST_NEXT;
                        end else begin
                            wait_cnt <= wait_cnt + 8'd1;
                        end
                    end
                    ST_READ: begin
                        if (wait_cnt == cfg_i.read_wait) begin
                            wait_cnt <= '0;
                            state    <= ST_NEXT;
                            if (sram_dq_i != pattern) begin
                                fail <= 1'b1;
                            end
                        end else begin
                            wait_cnt <= wait_cnt + 8'd1;
                        end
                    end
                    ST_NEXT: begin
                        if (!cfg_i.enable) begin
                            state <= ST_IDLE;
                        end else if (addr != last_addr) begin
                            addr  <= addr + 1'b1;
                            state <= read_phase ? ST_READ : ST_WR_SETUP;
                        end else if (!read_phase) begin
                            addr       <= '0;       // switch to read-back
                            read_phase <= 1'b1;
                            state      <= ST_READ;
                        end else begin
                            addr       <= '0;       // run done
                            read_phase <= 1'b0;
                            runs       <= runs + 1'b1;
                            if (!fail) begin
                                pass <= 1'b1;
                            end
                            state <= ST_WR_SETUP;
                        end
                    end
                    default: state <= ST_IDLE;
                endcase
            end
        end
    end

    assign access = (state == ST_WR_SETUP) || (state == ST_WR_STROBE) || (state == ST_READ);

    always_comb begin
        sram_o.addr   = addr;
        sram_o.dq_out = pattern;
        sram_o.dq_oe  = (state == ST_WR_SETUP) || (state == ST_WR_STROBE);
        sram_o.ce_n   = ~access;
        sram_o.we_n   = (state != ST_WR_STROBE);
        sram_o.oe_n   = (state != ST_READ);
        sram_o.lb_n   = ~access;    // both bytes on every access
        sram_o.ub_n   = ~access;
    end

    assign status_o.pass = pass;
    assign status_o.fail = fail;
    assign status_o.busy = (state != ST_IDLE);
    assign status_o.runs = runs;

endmodule

//--- led_status.sv
// heartbeat counter and user LED source select
module led_status (
    input  logic                          ext_clk,
    input  logic                          rst_i,
    input  board_test_pkg::led_cfg_t      led_cfg_i,
    input  board_test_pkg::sram_status_t  sram_status_i,
    output logic [7:0]                    usrled_o
);

    logic [board_test_pkg::HEARTBEAT_BITS-1:0] heartbeat;

    always_ff @(posedge ext_clk) begin
        if (rst_i) begin
            heartbeat <= '0;
        end else begin
            heartbeat <= heartbeat + 1'b1;
        end
    end

    always_comb begin
        if (led_cfg_i.test_mode) begin
            if (led_cfg_i.flash_all) begin
                usrled_o = {8{heartbeat[board_test_pkg::HEARTBEAT_BITS-2]}}; // fast blink
            end else begin
                usrled_o = led_cfg_i.test_leds;
            end
        end else begin
            usrled_o = {2'b00,
                        rst_i,
                        sram_status_i.pass,
                        sram_status_i.fail,
                        led_cfg_i.user_led,
                        sram_status_i.busy,
                        heartbeat[board_test_pkg::HEARTBEAT_BITS-1]};  // slow blink on bit 0
        end
    end

endmodule

//--- board_test_top.sv
// top level: register block, SRAM tester and LED driver
module board_test_top (
    input  logic                                    ext_clk,
    input  logic                                    rst_i,
    input  board_test_pkg::reg_addr_t               reg_addr_i,
    input  board_test_pkg::reg_data_t               reg_wdata_i,
    input  logic                                    reg_write_i,
    input  logic                                    reg_read_i,
    output board_test_pkg::reg_data_t               reg_rdata_o,
    input  logic [7:0]                              usrdip_i,
    output board_test_pkg::sram_pins_t              sram_o,
    input  logic [board_test_pkg::SRAM_DATA_W-1:0]  sram_dq_i,
    output logic [7:0]                              usrled_o
);

    board_test_pkg::sram_cfg_t    sram_cfg;
    board_test_pkg::sram_status_t sram_status;
    board_test_pkg::led_cfg_t     led_cfg;

    test_reg_block u_reg_block (
        .ext_clk        (ext_clk),
        .rst_i          (rst_i),
        .reg_addr_i     (reg_addr_i),
        .reg_wdata_i    (reg_wdata_i),
        .reg_write_i    (reg_write_i),
        .reg_read_i     (reg_read_i),
        .reg_rdata_o    (reg_rdata_o),
        .dips_i         (usrdip_i),
        .sram_status_i  (sram_status),
        .sram_cfg_o     (sram_cfg),
        .led_cfg_o      (led_cfg)
    );

    sram_rwtest u_sram_test (
        .ext_clk        (ext_clk),
        .rst_i          (rst_i),
        .cfg_i          (sram_cfg),
        .status_o       (sram_status),
        .sram_o         (sram_o),
        .sram_dq_i      (sram_dq_i)
    );

    led_status u_led_status (
        .ext_clk        (ext_clk),
        .rst_i          (rst_i),
        .led_cfg_i      (led_cfg),
        .sram_status_i  (sram_status),
        .usrled_o       (usrled_o)
    );

endmodule

//--- sram_model.sv
// behavioural SRAM for the testbench with byte enables and an optional stuck-at-one data bit
module sram_model (
    input  board_test_pkg::sram_pins_t              sram_i,
    output logic [board_test_pkg::SRAM_DATA_W-1:0]  dq_o,
    input  logic                                    fault_en_i,
    input  logic [3:0]                              fault_bit_i
);

    logic [board_test_pkg::SRAM_DATA_W-1:0] mem [0:(2**board_test_pkg::SRAM_ADDR_W)-1];
    logic [board_test_pkg::SRAM_DATA_W-1:0] fault_mask;

    // power-up contents differ from both test patterns
    initial begin
        for (int i = 0; i < 2**board_test_pkg::SRAM_ADDR_W; i++) begin
            mem[i] = 16'h5a5a ^ i[15:0] ^ {13'b0, i[18:16]};
        end
    end

    // word is taken when the write strobe falls, only bytes that are enabled and driven
    always @(negedge sram_i.we_n) begin
        if (!sram_i.ce_n && sram_i.dq_oe) begin
            if (!sram_i.lb_n) begin
                mem[sram_i.addr][7:0] <= sram_i.dq_out[7:0];
            end
            if (!sram_i.ub_n) begin
                mem[sram_i.addr][15:8] <= sram_i.dq_out[15:8];
            end
        end
    end

    always_comb begin
        fault_mask = '0;
        if (fault_en_i) begin
            fault_mask[fault_bit_i] = 1'b1;   // stuck at one
        end
    end

    assign dq_o = (!sram_i.ce_n && !sram_i.oe_n) ? (mem[sram_i.addr] | fault_mask) : '0;

endmodule

//--- tb_board_test.sv
// testbench top running the stimulus file against board_test_top and an SRAM model
module tb_board_test;

    logic                                   ext_clk = 1'b0;
    logic                                   rst_i;
    board_test_pkg::reg_addr_t              reg_addr;
    board_test_pkg::reg_data_t              reg_wdata;
    logic                                   reg_write;
    logic                                   reg_read;
    board_test_pkg::reg_data_t              reg_rdata;
    logic [7:0]                             dips;
    board_test_pkg::sram_pins_t             sram_pins;
    logic [board_test_pkg::SRAM_DATA_W-1:0] sram_dq;
    logic [7:0]                             leds;
    logic                                   fault_en;
    logic [3:0]                             fault_bit;
    logic [47:0]                            cmds [0:63];  // op, addr, value, mask, limit
    int                                     n_pass;
    int                                     n_fail;
    time                                    watchdog_time = 0;

    always #20 ext_clk = ~ext_clk;

    board_test_top dut0 (
        .ext_clk     (ext_clk),
        .rst_i       (rst_i),
        .reg_addr_i  (reg_addr),
        .reg_wdata_i (reg_wdata),
        .reg_write_i (reg_write),
        .reg_read_i  (reg_read),
        .reg_rdata_o (reg_rdata),
        .usrdip_i    (dips),
        .sram_o      (sram_pins),
        .sram_dq_i   (sram_dq),
        .usrled_o    (leds)
    );

    sram_model u_sram (
        .sram_i      (sram_pins),
        .dq_o        (sram_dq),
        .fault_en_i  (fault_en),
        .fault_bit_i (fault_bit)
    );

    task automatic bus_write(input logic [7:0] addr, input logic [7:0] data);
        @(posedge ext_clk);
        #5;
        reg_addr  = addr;
        reg_wdata = data;
        reg_write = 1'b1;
        @(posedge ext_clk);
        #5;
        reg_write = 1'b0;
    endtask

    // rdata is valid when this returns
    task automatic bus_read(input logic [7:0] addr);
        @(posedge ext_clk);
        #5;
        reg_addr = addr;
        reg_read = 1'b1;
        @(posedge ext_clk);
        #5;
        reg_read = 1'b0;
    endtask

    task automatic log_ok(input string name);
        $display("ok       %s", name);
        n_pass++;
    endtask

    task automatic log_mismatch(input string name, input logic [7:0] exp, input logic [7:0] act);
        $display("MISMATCH %s expected %02h actual %02h", name, exp, act);
        n_fail++;
    endtask

    initial begin : main_seq
        int          n_cmds;
        int          max_limit;
        int          waited;
        logic [7:0]  op;
        logic [7:0]  addr;
        logic [7:0]  value;
        logic [7:0]  mask;
        logic [15:0] limit;
        string       name;
        rst_i     = 1'b1;
        reg_addr  = '0;
        reg_wdata = '0;
        reg_write = 1'b0;
        reg_read  = 1'b0;
        dips      = '0;
        fault_en  = 1'b0;
        fault_bit = '0;
        n_pass    = 0;
        n_fail    = 0;
        for (int i = 0; i < $size(cmds); i++) begin
            cmds[i] = '0;
        end
        $readmemh("board_test_stimulus.txt", cmds);
        n_cmds    = 0;
        max_limit = 1;
        while (n_cmds < $size(cmds) && cmds[n_cmds][47:40] != 8'h00) begin
            if (cmds[n_cmds][15:0] > max_limit) begin
                max_limit = cmds[n_cmds][15:0];
            end
            n_cmds++;
        end
        watchdog_time = time'(n_cmds) * max_limit * 40;
        repeat (8) @(posedge ext_clk);
        #5;
        rst_i = 1'b0;
        for (int i = 0; i < n_cmds; i++) begin
            op    = cmds[i][47:40];
            addr  = cmds[i][39:32];
            value = cmds[i][31:24];
            mask  = cmds[i][23:16];
            limit = cmds[i][15:0];
            name  = $sformatf("cmd%0d (op %0h, addr %02h)", i + 1, op, addr);
            case (op)
                8'h01: bus_write(addr, value);
                8'h02: begin
                    bus_read(addr);
                    if ((reg_rdata & mask) !== (value & mask)) begin
                        log_mismatch(name, value & mask, reg_rdata & mask);
                    end else begin
                        log_ok(name);
                    end
                end
                8'h03: begin
                    bus_read(addr);
                    waited = 2;
                    while (((reg_rdata & mask) !== value) && waited < limit) begin
                        bus_read(addr);
                        waited += 2;
                    end
                    if ((reg_rdata & mask) !== value) begin
                        $display("FAIL     %s: %02h under mask %02h not seen in %0d cycles",
                                 name, value, mask, limit);
                        n_fail++;
                    end else begin
                        log_ok(name);
                    end
                end
                8'h04: begin
                    @(posedge ext_clk);
                    #5;
                    fault_en  = value[7];
                    fault_bit = value[3:0];
                end
                8'h05: begin
                    @(posedge ext_clk);
                    #5;
                    dips = value;
                end
                8'h06: begin
                    @(posedge ext_clk);
                    #5;
                    if ((leds & mask) !== (value & mask)) begin
                        log_mismatch(name, value & mask, leds & mask);
                    end else begin
                        log_ok(name);
                    end
                end
                default: begin
                    $display("FAIL     %s: unknown command code in stimulus file", name);
                    n_fail++;
                end
            endcase
        end
        $display("tests passed %0d, failed %0d", n_pass, n_fail);
        if (n_fail == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

    initial begin : watchdog
        wait (watchdog_time != 0);
        #(watchdog_time);
        $display("timeout: stimulus did not complete within %0t", watchdog_time);
        $display("SIMULATION FAILED");
        $finish;
    end

endmodule

//--- board_test_stimulus.txt
// op_addr_value_mask_limit: 01 write, 02 read (data & mask == value & mask), 03 poll within
// limit cycles, 04 fault (80 | bit), 05 dips, 06 leds (leds & mask == value & mask)
02_00_00_ff_0000   // reset values
02_01_00_ff_0000
02_02_00_ff_0000
02_03_00_ff_0000
02_04_00_ff_0000
02_05_00_ff_0000
02_10_00_ff_0000
02_11_00_ff_0000
02_13_00_ff_0000
06_00_00_fe_0000   // leds with heartbeat bit masked
01_01_01_00_0000   // top address 1, small waits
01_02_02_00_0000
01_03_01_00_0000
01_04_03_00_0000
01_11_a5_00_0000
05_00_3c_00_0000
02_01_01_ff_0000
02_02_02_ff_0000
02_03_01_ff_0000
02_04_03_ff_0000
02_11_a5_ff_0000
02_12_3c_ff_0000
01_00_01_00_0000   // enable, wait for pass with fail clear
03_05_01_03_03e8
02_08_01_ff_0000   // first run only just ended
01_00_00_00_0000   // stop, stuck bit 0, wait for idle
04_00_80_00_0000
03_05_00_04_0064
01_00_01_00_0000   // rising enable clears run count
02_08_00_ff_0000
03_05_02_03_03e8   // fail set, pass clear
01_10_01_00_0000   // test mode
06_00_a5_ff_0000
01_10_03_00_0000   // flash all, heartbeat bit 23 still low
06_00_00_ff_0000
01_10_00_00_0000   // normal mode, fail on bit 3, user led on bit 2
01_13_01_00_0000
06_00_0c_fc_0000

//--- verilog.f
board_test_pkg.sv
test_reg_block.sv
sram_rwtest.sv
led_status.sv
board_test_top.sv
sram_model.sv
tb_board_test.sv

//--- Bender.yml
package:
  name: board_test

sources:
  - board_test_pkg.sv
  - test_reg_block.sv
  - sram_rwtest.sv
  - led_status.sv
  - board_test_top.sv
  - target: test
    files:
      - sram_model.sv
      - tb_board_test.sv
